/* rtl/dcache_pkg.sv */
package dcache_pkg;

    localparam int XLEN            = 64;
    localparam int ADDR_W          = 32;
    localparam int OFFSET_W        = 3;
    localparam int DEFAULT_INDEX_W = 8;
    localparam int ROB_W           = 4;
    localparam int BUS_W           = 32;

    // bit 2 set means zero extension on loads
    typedef enum logic [2:0] {
        SZ_B  = 3'b000,
        SZ_H  = 3'b001,
        SZ_W  = 3'b010,
        SZ_D  = 3'b011,
        SZ_BU = 3'b100,
        SZ_HU = 3'b101,
        SZ_WU = 3'b110
    } size_e;

    typedef logic [XLEN-1:0] line_t;

    typedef struct packed {
        logic              is_store;
        size_e             size;
        logic [ADDR_W-1:0] addr;
        logic [XLEN-1:0]   st_data;
        logic [ROB_W-1:0]  rob;
    } cache_req_t;

    typedef struct packed {
        logic [XLEN-1:0]  ld_data;
        logic [ROB_W-1:0] rob;
    } cache_resp_t;

    // decoded access, store data already shifted to its byte lanes
    typedef struct packed {
        logic              valid;
        logic              is_store;
        size_e             size;
        logic [ADDR_W-1:0] addr;
        logic [XLEN/8-1:0] byte_en;
        logic [XLEN-1:0]   st_data;
        logic [ROB_W-1:0]  rob;
    } stage_t;

    typedef struct packed {
        logic              cyc;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [BUS_W-1:0]  dat;
    } mem_req_t;

    // store bytes over an existing line
    function automatic line_t merge_line(line_t old_line, stage_t st);
        line_t res;
        res = old_line;
        for (int i = 0; i < XLEN / 8; i++) begin
            if (st.byte_en[i]) begin
                res[8*i +: 8] = st.st_data[8*i +: 8];
            end
        end
        return res;
    endfunction

endpackage

/* rtl/dcache_req_decode.sv */
`timescale 1ns/1ns

module dcache_req_decode (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   req_valid_i,
    input  dcache_pkg::cache_req_t req_i,
    input  logic                   stall_i,
    input  logic                   busy_i,
    output logic                   req_ready_o,
    output dcache_pkg::stage_t     stage_o
);

    logic                      ready_en_q;
    logic                      hold;
    logic [7:0]                size_mask;
    logic [dcache_pkg::OFFSET_W-1:0] offs;
    dcache_pkg::stage_t        stage_d;

    // frozen by result back-pressure or an open miss
    assign hold        = stall_i | busy_i;
    assign req_ready_o = ready_en_q & ~hold;
    assign offs        = req_i.addr[dcache_pkg::OFFSET_W-1:0];

    always_comb begin
        case (req_i.size[1:0])
            2'b00:   size_mask = 8'h01;
            2'b01:   size_mask = 8'h03;
            2'b10:   size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
        stage_d.valid    = req_valid_i & req_ready_o;
        stage_d.is_store = req_i.is_store;
        stage_d.size     = req_i.size;
        stage_d.addr     = req_i.addr;
        stage_d.byte_en  = size_mask << offs;
        stage_d.st_data  = req_i.st_data << {offs, 3'b000};
        stage_d.rob      = req_i.rob;
    end

    always_ff @(posedge clk) begin
        if (rstn) begin
            ready_en_q <= 1'b0;
            stage_o    <= '0;
        end else begin
            ready_en_q <= 1'b1;
            if (!hold) begin
                stage_o <= stage_d;
            end
        end
    end

endmodule

/* rtl/dcache_lookup.sv */
`timescale 1ns/1ns

module dcache_lookup #(
    parameter  int INDEX_W = dcache_pkg::DEFAULT_INDEX_W,
    localparam int TAG_W   = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W
) (
    input  logic               clk,
    input  logic               rstn,
    input  dcache_pkg::stage_t stage_i,
    input  logic               stall_i,
    // refill install from the miss unit
    input  logic               install_valid_i,
    input  logic [INDEX_W-1:0] install_index_i,
    input  logic [TAG_W-1:0]   install_tag_i,
    input  dcache_pkg::line_t  install_line_i,
    input  logic               install_dirty_i,
    output dcache_pkg::stage_t hit_o,
    output dcache_pkg::line_t  hit_line_o,
    // miss request, taken by the miss unit on the same edge
    output logic               miss_valid_o,
    output dcache_pkg::stage_t miss_stage_o,
    output logic [TAG_W-1:0]   miss_tag_o,
    output logic               miss_dirty_o,
    output dcache_pkg::line_t  miss_line_o,
    output logic               busy_o
);

    localparam int SETS = 1 << INDEX_W;

    logic [TAG_W-1:0]  tag_arr  [SETS];
    dcache_pkg::line_t data_arr [SETS];
    logic [SETS-1:0]   valid_arr;
    logic [SETS-1:0]   dirty_arr;

    logic [INDEX_W-1:0] idx;
    logic [INDEX_W-1:0] hit_idx;
    logic [TAG_W-1:0]   tag;
    logic               fwd;
    logic               is_hit;
    logic               active;
    logic               st_commit;
    dcache_pkg::line_t  rd_line;

    assign idx     = stage_i.addr[dcache_pkg::OFFSET_W +: INDEX_W];
    assign tag     = stage_i.addr[dcache_pkg::ADDR_W-1 -: TAG_W];
    assign hit_idx = hit_o.addr[dcache_pkg::OFFSET_W +: INDEX_W];

    // store one stage ahead writes its line on the next edge
    assign st_commit = hit_o.valid & hit_o.is_store & ~stall_i;
    assign fwd       = hit_o.valid & hit_o.is_store & (hit_idx == idx);
    assign rd_line   = fwd ? hit_line_o : data_arr[idx];

    assign is_hit = valid_arr[idx] & (tag_arr[idx] == tag);
    assign active = stage_i.valid & ~stall_i & ~busy_o;

    assign miss_valid_o = active & ~is_hit;
    assign miss_stage_o = stage_i;
    assign miss_tag_o   = tag_arr[idx];
    assign miss_dirty_o = valid_arr[idx] & (dirty_arr[idx] | fwd);
    assign miss_line_o  = rd_line;

    ////////////////////////////////////////////////////////////////////////////
    // state bits

    always_ff @(posedge clk) begin
        if (rstn) begin
            valid_arr <= '0;
            dirty_arr <= '0;
            busy_o    <= 1'b0;
            hit_o     <= '0;
        end else begin
            if (!stall_i) begin
                hit_o       <= stage_i;
                hit_o.valid <= active & is_hit;
            end
            // held until the refilled line is in place
            if (miss_valid_o) begin
                busy_o <= 1'b1;
            end else if (install_valid_i) begin
                busy_o <= 1'b0;
            end
            if (st_commit) begin
                dirty_arr[hit_idx] <= 1'b1;
            end
            if (install_valid_i) begin
                valid_arr[install_index_i] <= 1'b1;
                dirty_arr[install_index_i] <= install_dirty_i;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // line and tag storage

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            if (stage_i.is_store) begin
                hit_line_o <= dcache_pkg::merge_line(rd_line, stage_i);
            end else begin
                hit_line_o <= rd_line;
            end
        end
        if (st_commit) begin
            data_arr[hit_idx] <= hit_line_o;
        end
        if (install_valid_i) begin
            data_arr[install_index_i] <= install_line_i;
            tag_arr[install_index_i]  <= install_tag_i;
        end
    end

endmodule

/* rtl/dcache_miss_unit.sv */
`timescale 1ns/1ns

module dcache_miss_unit #(
    parameter  int INDEX_W = dcache_pkg::DEFAULT_INDEX_W,
    localparam int TAG_W   = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         miss_valid_i,
    input  dcache_pkg::stage_t           miss_stage_i,
    input  logic [TAG_W-1:0]             miss_tag_i,
    input  logic                         miss_dirty_i,
    input  dcache_pkg::line_t            miss_line_i,
    output dcache_pkg::mem_req_t         mem_o,
    input  logic                         mem_ack_i,
    input  logic [dcache_pkg::BUS_W-1:0] mem_rdata_i,
    output logic                         install_valid_o,
    output logic [INDEX_W-1:0]           install_index_o,
    output logic [TAG_W-1:0]             install_tag_o,
    output dcache_pkg::line_t            install_line_o,
    output logic                         install_dirty_o,
    output logic                         ld_resp_valid_o,
    output dcache_pkg::stage_t           ld_stage_o,
    output dcache_pkg::line_t            ld_line_o
);

    localparam int BW = dcache_pkg::BUS_W;

    typedef enum logic [2:0] {
        MS_IDLE,
        MS_WB0,
        MS_WB1,
        MS_RD0,
        MS_RD1,
        MS_DONE
    } miss_state_e;

    miss_state_e        state;
    dcache_pkg::stage_t ent_stage;
    logic [TAG_W-1:0]   ent_vtag;
    dcache_pkg::line_t  ent_line;
    logic [INDEX_W-1:0] ent_index;
    logic               upper;

    assign ent_index = ent_stage.addr[dcache_pkg::OFFSET_W +: INDEX_W];
    // second beat moves the upper word
    assign upper     = (state == MS_WB1) | (state == MS_RD1);

    always_comb begin
        mem_o.cyc = (state != MS_IDLE) & (state != MS_DONE);
        mem_o.we  = (state == MS_WB0) | (state == MS_WB1);
        if (mem_o.we) begin
            mem_o.adr = {ent_vtag, ent_index, upper, 2'b00};
        end else begin
            mem_o.adr = {ent_stage.addr[dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W], upper, 2'b00};
        end
        mem_o.dat = upper ? ent_line[BW +: BW] : ent_line[0 +: BW];
    end

    // store misses leave the line dirty with the store merged in
    assign install_valid_o = (state == MS_DONE);
    assign install_index_o = ent_index;
    assign install_tag_o   = ent_stage.addr[dcache_pkg::ADDR_W-1 -: TAG_W];
    assign install_dirty_o = ent_stage.is_store;
    assign install_line_o  = ent_stage.is_store ? dcache_pkg::merge_line(ent_line, ent_stage)
                                                : ent_line;

    assign ld_resp_valid_o = install_valid_o & ~ent_stage.is_store;
    assign ld_stage_o      = ent_stage;
    assign ld_line_o       = ent_line;

    always_ff @(posedge clk) begin
        if (rstn) begin
            state <= MS_IDLE;
        end else begin
            case (state)
                MS_IDLE: begin
                    if (miss_valid_i) begin
                        state <= miss_dirty_i ? MS_WB0 : MS_RD0;
                    end
                end
                MS_WB0:  if (mem_ack_i) state <= MS_WB1;
                MS_WB1:  if (mem_ack_i) state <= MS_RD0;
                MS_RD0:  if (mem_ack_i) state <= MS_RD1;
                MS_RD1:  if (mem_ack_i) state <= MS_DONE;
                default: state <= MS_IDLE;
            endcase
        end
    end

    // victim line is reused as the refill buffer
    always_ff @(posedge clk) begin
        if (state == MS_IDLE && miss_valid_i) begin
            ent_stage <= miss_stage_i;
            ent_vtag  <= miss_tag_i;
            ent_line  <= miss_line_i;
        end
        if (mem_ack_i && state == MS_RD0) begin
            ent_line[0 +: BW] <= mem_rdata_i;
        end
        if (mem_ack_i && state == MS_RD1) begin
            ent_line[BW +: BW] <= mem_rdata_i;
        end
    end

endmodule

/* rtl/dcache_load_result.sv */
`timescale 1ns/1ns

module dcache_load_result (
    input  logic                    clk,
    input  logic                    rstn,
    input  dcache_pkg::stage_t      hit_i,
    input  dcache_pkg::line_t       hit_line_i,
    input  logic                    ld_resp_valid_i,
    input  dcache_pkg::stage_t      ld_stage_i,
    input  dcache_pkg::line_t       ld_line_i,
    input  logic                    resp_ready_i,
    output logic                    resp_valid_o,
    output dcache_pkg::cache_resp_t resp_o,
    output logic                    stall_o
);

    logic                            take;
    logic                            src_valid;
    logic                            pend_valid;
    dcache_pkg::stage_t              src_stage;
    dcache_pkg::stage_t              pend_stage;
    dcache_pkg::line_t               src_line;
    dcache_pkg::line_t               pend_line;
    dcache_pkg::line_t               lane;
    logic [dcache_pkg::XLEN-1:0]     ld_data;

    assign take    = ~resp_valid_o | resp_ready_i;
    assign stall_o = ~take | pend_valid;

    always_comb begin
        // a parked miss response goes first
        if (pend_valid) begin
            src_valid = 1'b1;
            src_stage = pend_stage;
            src_line  = pend_line;
        end else if (ld_resp_valid_i) begin
            src_valid = 1'b1;
            src_stage = ld_stage_i;
            src_line  = ld_line_i;
        end else begin
            src_valid = hit_i.valid & ~hit_i.is_store;
            src_stage = hit_i;
            src_line  = hit_line_i;
        end
        lane = src_line >> {src_stage.addr[dcache_pkg::OFFSET_W-1:0], 3'b000};
        case (src_stage.size)
            dcache_pkg::SZ_B:  ld_data = {{56{lane[7]}}, lane[7:0]};
            dcache_pkg::SZ_H:  ld_data = {{48{lane[15]}}, lane[15:0]};
            dcache_pkg::SZ_W:  ld_data = {{32{lane[31]}}, lane[31:0]};
            dcache_pkg::SZ_BU: ld_data = {56'b0, lane[7:0]};
            dcache_pkg::SZ_HU: ld_data = {48'b0, lane[15:0]};
            dcache_pkg::SZ_WU: ld_data = {32'b0, lane[31:0]};
            default:           ld_data = lane;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rstn) begin
            resp_valid_o <= 1'b0;
            pend_valid   <= 1'b0;
        end else begin
            if (take) begin
                resp_valid_o <= src_valid;
                pend_valid   <= 1'b0;
            end else if (ld_resp_valid_i) begin
                pend_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && src_valid) begin
            resp_o.ld_data <= ld_data;
            resp_o.rob     <= src_stage.rob;
        end
        if (ld_resp_valid_i) begin
            pend_stage <= ld_stage_i;
            pend_line  <= ld_line_i;
        end
    end

endmodule

/* rtl/l1_dcache.sv */
`timescale 1ns/1ns

module l1_dcache #(
    parameter  int INDEX_W = dcache_pkg::DEFAULT_INDEX_W,
    localparam int TAG_W   = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::OFFSET_W
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         req_valid_i,
    output logic                         req_ready_o,
    input  dcache_pkg::cache_req_t       req_i,
    output logic                         resp_valid_o,
    input  logic                         resp_ready_i,
    output dcache_pkg::cache_resp_t      resp_o,
    output dcache_pkg::mem_req_t         mem_o,
    input  logic                         mem_ack_i,
    input  logic [dcache_pkg::BUS_W-1:0] mem_rdata_i
);

    logic               stall;
    logic               busy;
    dcache_pkg::stage_t dec_stage;
    dcache_pkg::stage_t hit_stage;
    dcache_pkg::line_t  hit_line;

    logic               miss_valid;
    dcache_pkg::stage_t miss_stage;
    logic [TAG_W-1:0]   miss_tag;
    logic               miss_dirty;
    dcache_pkg::line_t  miss_line;

    logic               install_valid;
    logic [INDEX_W-1:0] install_index;
    logic [TAG_W-1:0]   install_tag;
    dcache_pkg::line_t  install_line;
    logic               install_dirty;

    logic               ld_resp_valid;
    dcache_pkg::stage_t ld_stage;
    dcache_pkg::line_t  ld_line;

    dcache_req_decode i_decode (
        .clk         (clk),
        .rstn        (rstn),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .stall_i     (stall),
        .busy_i      (busy),
        .req_ready_o (req_ready_o),
        .stage_o     (dec_stage)
    );

    dcache_lookup #(
        .INDEX_W (INDEX_W)
    ) i_lookup (
        .clk             (clk),
        .rstn            (rstn),
        .stage_i         (dec_stage),
        .stall_i         (stall),
        .install_valid_i (install_valid),
        .install_index_i (install_index),
        .install_tag_i   (install_tag),
        .install_line_i  (install_line),
        .install_dirty_i (install_dirty),
        .hit_o           (hit_stage),
        .hit_line_o      (hit_line),
        .miss_valid_o    (miss_valid),
        .miss_stage_o    (miss_stage),
        .miss_tag_o      (miss_tag),
        .miss_dirty_o    (miss_dirty),
        .miss_line_o     (miss_line),
        .busy_o          (busy)
    );

    dcache_miss_unit #(
        .INDEX_W (INDEX_W)
    ) i_miss (
        .clk             (clk),
        .rstn            (rstn),
        .miss_valid_i    (miss_valid),
        .miss_stage_i    (miss_stage),
        .miss_tag_i      (miss_tag),
        .miss_dirty_i    (miss_dirty),
        .miss_line_i     (miss_line),
        .mem_o           (mem_o),
        .mem_ack_i       (mem_ack_i),
        .mem_rdata_i     (mem_rdata_i),
        .install_valid_o (install_valid),
        .install_index_o (install_index),
        .install_tag_o   (install_tag),
        .install_line_o  (install_line),
        .install_dirty_o (install_dirty),
        .ld_resp_valid_o (ld_resp_valid),
        .ld_stage_o      (ld_stage),
        .ld_line_o       (ld_line)
    );

    dcache_load_result i_result (
        .clk             (clk),
        .rstn            (rstn),
        .hit_i           (hit_stage),
        .hit_line_i      (hit_line),
        .ld_resp_valid_i (ld_resp_valid),
        .ld_stage_i      (ld_stage),
        .ld_line_i       (ld_line),
        .resp_ready_i    (resp_ready_i),
        .resp_valid_o    (resp_valid_o),
        .resp_o          (resp_o),
        .stall_o         (stall)
    );

endmodule

/* sim/tb_l1_dcache.sv */
`timescale 1ns/1ns

module tb_l1_dcache;

    localparam int TIMEOUT_CYC = 500;
    localparam int MAX_OPS     = 64;
    localparam int INDEX_W     = dcache_pkg::DEFAULT_INDEX_W;
    localparam int SETS        = 1 << INDEX_W;
    localparam int LINE_W      = dcache_pkg::ADDR_W - dcache_pkg::OFFSET_W;

    logic                         clk;
    logic                         rstn;
    logic                         req_valid_i;
    logic                         req_ready_o;
    dcache_pkg::cache_req_t       req_i;
    logic                         resp_valid_o;
    logic                         resp_ready_i;
    dcache_pkg::cache_resp_t      resp_o;
    dcache_pkg::mem_req_t         mem_o;
    logic                         mem_ack_i;
    logic [dcache_pkg::BUS_W-1:0] mem_rdata_i;

    logic [31:0] mem     [16384];
    logic [31:0] ref_mem [16384];
    logic [31:0] lfsr_q;

    logic [LINE_W-1:0] set_line  [SETS];
    logic              set_valid [SETS];
    logic              set_dirty [SETS];
    logic [31:0]       wb_adr_q [$];

    logic [3:0]  g_kind [MAX_OPS];
    logic [2:0]  g_size [MAX_OPS];
    logic [31:0] g_addr [MAX_OPS];
    logic [63:0] g_data [MAX_OPS];
    logic [3:0]  g_rob  [MAX_OPS];
    logic [63:0] g_exp  [MAX_OPS];
    int          n_ops;

    dcache_pkg::cache_resp_t exp_q [$];
    int                      exp_op_q [$];
    int                      value_errors;
    int                      other_errors;

    l1_dcache #(
        .INDEX_W (INDEX_W)
    ) i_dut (
        .clk          (clk),
        .rstn         (rstn),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_i        (req_i),
        .resp_valid_o (resp_valid_o),
        .resp_ready_i (resp_ready_i),
        .resp_o       (resp_o),
        .mem_o        (mem_o),
        .mem_ack_i    (mem_ack_i),
        .mem_rdata_i  (mem_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois lfsr, one step per bit
    function automatic logic rand_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ 32'h80200003;
        end
        return b;
    endfunction

    task automatic check_resp(input string name, input dcache_pkg::cache_resp_t exp,
                              input dcache_pkg::cache_resp_t act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_mem_write(input string name, input dcache_pkg::mem_req_t exp,
                                   input dcache_pkg::mem_req_t act);
        if (exp !== act) begin
            $display("ERR %s expected %h actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    task automatic load_golden();
        int    fd;
        int    cnt;
        string line;
        fd = $fopen("sim/dcache_golden.txt", "r");
        n_ops = 0;
        if (fd == 0) begin
            $display("could not open the golden file");
            other_errors++;
        end else begin
            while (!$feof(fd) && n_ops < MAX_OPS) begin
                cnt = $fgets(line, fd);
                if (cnt > 0 && line.len() > 5 && line[0] != "#") begin
                    cnt = $sscanf(line, "%h %h %h %h %h %h", g_kind[n_ops], g_size[n_ops],
                                  g_addr[n_ops], g_data[n_ops], g_rob[n_ops], g_exp[n_ops]);
                    if (cnt == 6) begin
                        n_ops++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // model of memory after all stores, used for write-back data
    task automatic apply_store(input int n);
        logic [31:0] a;
        for (int b = 0; b < (1 << g_size[n][1:0]); b++) begin
            a = g_addr[n] + b;
            ref_mem[a[15:2]][8*a[1:0] +: 8] = g_data[n][8*b +: 8];
        end
    endtask

    // direct-mapped residency, a dirty line leaving its set is written back
    task automatic track_line(input int n);
        logic [INDEX_W-1:0] sidx;
        logic [LINE_W-1:0]  line;
        sidx = g_addr[n][dcache_pkg::OFFSET_W +: INDEX_W];
        line = g_addr[n][dcache_pkg::ADDR_W-1:dcache_pkg::OFFSET_W];
        if (set_valid[sidx] && set_line[sidx] != line) begin
            if (set_dirty[sidx]) begin
                wb_adr_q.push_back({set_line[sidx], 3'd0});
                wb_adr_q.push_back({set_line[sidx], 3'd4});
            end
            set_dirty[sidx] = 1'b0;
        end
        set_valid[sidx] = 1'b1;
        set_line[sidx]  = line;
        if (g_kind[n][0]) begin
            set_dirty[sidx] = 1'b1;
        end
    endtask

    task automatic issue_op(input int n, output logic stuck);
        int                      waited;
        dcache_pkg::cache_resp_t exp;
        stuck = 1'b0;
        @(negedge clk);
        req_valid_i      = 1'b1;
        req_i.is_store   = g_kind[n][0];
        req_i.size       = dcache_pkg::size_e'(g_size[n]);
        req_i.addr       = g_addr[n];
        req_i.st_data    = g_data[n];
        req_i.rob        = g_rob[n];
        #1;
        waited = 0;
        while (!req_ready_o && waited < TIMEOUT_CYC) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!req_ready_o) begin
            $display("timeout: request of op%0d was never accepted", n);
            other_errors++;
            stuck = 1'b1;
        end else begin
            track_line(n);
            if (g_kind[n][0]) begin
                apply_store(n);
            end else begin
                exp.ld_data = g_exp[n];
                exp.rob     = g_rob[n];
                exp_q.push_back(exp);
                exp_op_q.push_back(n);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // response side with random back-pressure

    initial begin
        logic                    held;
        dcache_pkg::cache_resp_t held_resp;
        string                   name;
        held = 1'b0;
        forever begin
            @(negedge clk);
            resp_ready_i = (rstn == 1'b0) & (rand_bit() | rand_bit());
            #1;
            if (held && !resp_valid_o) begin
                $display("a waiting response was withdrawn before it was taken");
                other_errors++;
            end else if (held) begin
                check_resp("hold_stable", held_resp, resp_o);
            end
            if (resp_valid_o && resp_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("response seen while no load was pending");
                    other_errors++;
                end else begin
                    name = $sformatf("op%0d", exp_op_q.pop_front());
                    check_resp(name, exp_q.pop_front(), resp_o);
                end
            end
            held      = resp_valid_o & ~resp_ready_i;
            held_resp = resp_o;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // memory bus model

    initial begin
        int                   delay;
        logic [13:0]          w;
        dcache_pkg::mem_req_t exp;
        delay = -1;
        forever begin
            @(negedge clk);
            if (mem_ack_i) begin
                mem_ack_i = 1'b0;
            end else if (rstn == 1'b0 && mem_o.cyc) begin
                if (delay < 0) begin
                    delay = int'({rand_bit(), rand_bit()});
                end
                if (delay == 0) begin
                    w = mem_o.adr[15:2];
                    mem_ack_i   = 1'b1;
                    mem_rdata_i = mem[w];
                    if (mem_o.we) begin
                        if (wb_adr_q.size() == 0) begin
                            $display("write-back seen while no dirty line was evicted");
                            other_errors++;
                        end else begin
                            exp.cyc = 1'b1;
                            exp.we  = 1'b1;
                            exp.adr = wb_adr_q.pop_front();
                            exp.dat = ref_mem[exp.adr[15:2]];
                            check_mem_write("write_back", exp, mem_o);
                        end
                        mem[w] = mem_o.dat;
                    end
                    delay = -1;
                end else begin
                    delay--;
                end
            end
        end
    end

    initial begin
        int   waited;
        logic stuck;
        value_errors = 0;
        other_errors = 0;
        lfsr_q       = 32'h4f89ff2a;
        for (int i = 0; i < 16384; i++) begin
            mem[i[13:0]]     = {i[29:0], 2'b00} ^ 32'h5a5a0000;
            ref_mem[i[13:0]] = {i[29:0], 2'b00} ^ 32'h5a5a0000;
        end
        for (int s = 0; s < SETS; s++) begin
            set_valid[s] = 1'b0;
            set_dirty[s] = 1'b0;
            set_line[s]  = '0;
        end
        rstn         = 1'b1;
        req_valid_i  = 1'b0;
        req_i        = '0;
        resp_ready_i = 1'b0;
        mem_ack_i    = 1'b0;
        mem_rdata_i  = '0;
        load_golden();
        repeat (9) @(negedge clk);
        if (req_ready_o || resp_valid_o || mem_o.cyc) begin
            $display("ready, response valid or bus cycle active during reset");
            other_errors++;
        end
        @(negedge clk);
        rstn = 1'b0;
        stuck = 1'b0;
        for (int n = 0; n < n_ops && !stuck; n++) begin
            issue_op(n, stuck);
        end
        if (!stuck) begin
            @(negedge clk);
            req_valid_i = 1'b0;
            waited = 0;
            while ((exp_q.size() != 0 || mem_o.cyc || !req_ready_o) && waited < TIMEOUT_CYC) begin
                @(negedge clk);
                #1;
                waited++;
            end
            if (waited >= TIMEOUT_CYC) begin
                $display("timeout: pending load responses or bus activity never drained");
                other_errors++;
            end
            if (wb_adr_q.size() != 0) begin
                $display("an expected write-back never appeared on the bus");
                other_errors++;
            end
        end
        finish_run();
    end

endmodule

/* sim/dcache_golden.txt */
# columns: kind (0 load, 1 store), size code, address, store data, rob, expected load data
# all fields hex, expected load data is 0 for stores
0 0 000000f0 0000000000000000 1 fffffffffffffff0
0 4 000000f0 0000000000000000 2 00000000000000f0
0 1 00008a10 0000000000000000 3 ffffffffffff8a10
0 5 00008a10 0000000000000000 4 0000000000008a10
0 2 00009c22 0000000000000000 5 ffffffff9c245a5a
0 6 00009c22 0000000000000000 6 000000009c245a5a
0 3 00000300 0000000000000000 7 5a5a03045a5a0300
1 0 000000f3 00000000000000a5 8 0000000000000000
0 3 000000f0 0000000000000000 9 5a5a00f4a55a00f0
1 1 000000f4 000000000000beef a 0000000000000000
0 5 000000f4 0000000000000000 b 000000000000beef
1 2 000000f0 0000000012345678 c 0000000000000000
0 2 000000f0 0000000000000000 d 0000000012345678
1 3 000000f0 deadbeefcafef00d e 0000000000000000
0 0 000000f7 0000000000000000 f ffffffffffffffde
0 3 000000f0 0000000000000000 0 deadbeefcafef00d
0 3 00008a10 0000000000000000 1 5a5a8a145a5a8a10
0 6 00009c24 0000000000000000 2 000000005a5a9c24
0 1 00000302 0000000000000000 3 0000000000005a5a
0 4 000000f1 0000000000000000 4 00000000000000f0
0 3 000008f0 0000000000000000 5 5a5a08f45a5a08f0
0 3 000000f0 0000000000000000 6 deadbeefcafef00d
1 1 00004a06 0000000000007e11 7 0000000000000000
0 3 00004a00 0000000000000000 8 7e114a045a5a4a00
1 0 00004a01 0000000000000080 9 0000000000000000
0 0 00004a01 0000000000000000 a ffffffffffffff80
0 2 00005200 0000000000000000 b 000000005a5a5200
0 3 00004a00 0000000000000000 c 7e114a045a5a8000
0 5 00009c26 0000000000000000 d 0000000000005a5a
0 0 00008a11 0000000000000000 e ffffffffffffff8a
0 3 00000300 0000000000000000 f 5a5a03045a5a0300
0 6 000008f4 0000000000000000 0 000000005a5a08f4

/* compile.f */
rtl/dcache_pkg.sv
rtl/dcache_req_decode.sv
rtl/dcache_lookup.sv
rtl/dcache_miss_unit.sv
rtl/dcache_load_result.sv
rtl/l1_dcache.sv
sim/tb_l1_dcache.sv

/* run_sim.sh */
#!/bin/bash
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_l1_dcache -f compile.f -Mdir obj_dir \
    && ./obj_dir/Vtb_l1_dcache | tee sim.log \
    && grep -q "^TB PASSED$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
